// File: rtl/complex_mac.sv
`timescale 1ns/1ps
`default_nettype none

module complex_mac (
	input  wire                     clk,
	input  wire                     reset_n,
	input  wire qsim_pkg::mac_cmd_t mac_cmd,
	input  wire qsim_pkg::complex_t gate_data,
	input  wire qsim_pkg::complex_t in_data,
	input  wire qsim_pkg::complex_t buf_data,
	output qsim_pkg::buf_wr_t       buf_wr,
	output qsim_pkg::out_wr_t       out_wr
);
	import qsim_pkg::*;

	complex_t                   state_op;
	mac_cmd_t                   cmd_p1;
	logic signed [2*ELEM_W-1:0] p_ac;
	logic signed [2*ELEM_W-1:0] p_bd;
	logic signed [2*ELEM_W-1:0] p_ad;
	logic signed [2*ELEM_W-1:0] p_bc;
	logic signed [ACC_W-1:0]    term_re;
	logic signed [ACC_W-1:0]    term_im;
	logic signed [ACC_W-1:0]    sum_re;
	logic signed [ACC_W-1:0]    sum_im;
	logic signed [ACC_W-1:0]    acc_re;
	logic signed [ACC_W-1:0]    acc_im;
	logic signed [ACC_W-1:0]    scaled_re;
	logic signed [ACC_W-1:0]    scaled_im;
	logic                       buf_en;
	logic                       out_en;
	logic                       wr_bank;
	logic [BUF_ADDR_W-1:0]      wr_row;
	complex_t                   wr_data;

	// ----------------------------------------------------------
	// stage 1: operand select and partial products
	// ----------------------------------------------------------
	assign state_op = mac_cmd.from_input ? in_data : buf_data;

	always_ff @(posedge clk) begin
		p_ac <= (2*ELEM_W)'(gate_data.re) * (2*ELEM_W)'(state_op.re);
		p_bd <= (2*ELEM_W)'(gate_data.im) * (2*ELEM_W)'(state_op.im);
		p_ad <= (2*ELEM_W)'(gate_data.re) * (2*ELEM_W)'(state_op.im);
		p_bc <= (2*ELEM_W)'(gate_data.im) * (2*ELEM_W)'(state_op.re);
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cmd_p1 <= '0;
		end else begin
			cmd_p1 <= mac_cmd;
		end
	end

	// ----------------------------------------------------------
	// stage 2: accumulate, scale on the last term
	// ----------------------------------------------------------
	assign term_re   = ACC_W'(p_ac) - ACC_W'(p_bd);  // ac - bd
	assign term_im   = ACC_W'(p_ad) + ACC_W'(p_bc);  // ad + bc
	assign sum_re    = cmd_p1.first ? term_re : acc_re + term_re;
	assign sum_im    = cmd_p1.first ? term_im : acc_im + term_im;
	assign scaled_re = sum_re >>> FRAC_BITS;  // back to Q2.14, top bits wrap
	assign scaled_im = sum_im >>> FRAC_BITS;

	always_ff @(posedge clk) begin
		if (cmd_p1.valid) begin
			acc_re <= sum_re;
			acc_im <= sum_im;
		end
		if (cmd_p1.valid && cmd_p1.last) begin
			wr_bank    <= cmd_p1.wr_bank;
			wr_row     <= cmd_p1.row;
			wr_data.re <= scaled_re[ELEM_W-1:0];
			wr_data.im <= scaled_im[ELEM_W-1:0];
		end
	end

	// intermediate gates feed the buffer, the final gate the output SRAM
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			buf_en <= 1'b0;
			out_en <= 1'b0;
		end else begin
			buf_en <= cmd_p1.valid && cmd_p1.last && !cmd_p1.final_gate;
			out_en <= cmd_p1.valid && cmd_p1.last && cmd_p1.final_gate;
		end
	end

	assign buf_wr = '{en: buf_en, bank: wr_bank, row: wr_row, data: wr_data};
	assign out_wr = '{en: out_en, addr: STATE_ADDR_W'(wr_row), data: wr_data};

endmodule

`default_nettype wire

// File: rtl/qsim_pkg.sv
`default_nettype none

package qsim_pkg;

	// ----------------------------------------------------------
	// sizes
	// ----------------------------------------------------------
	localparam int ELEM_W       = 16;  // one real or imaginary part
	localparam int FRAC_BITS    = 14;  // Q2.14
	localparam int ACC_W        = 40;  // per-part accumulator, room for 16 full products
	localparam int MAX_QUBITS   = 4;
	localparam int MAX_STATES   = 1 << MAX_QUBITS;
	localparam int MAX_GATES    = 8;
	localparam int STATE_ADDR_W = $clog2(MAX_STATES + 1);  // header word plus vector
	localparam int BUF_ADDR_W   = $clog2(MAX_STATES);
	localparam int GATE_ADDR_W  = $clog2(MAX_GATES * MAX_STATES * MAX_STATES);
	localparam int CNT_W        = 16;  // q and m header fields
	localparam int MAC_DEPTH    = 2;   // last term in to write strobe out

	// ----------------------------------------------------------
	// data words
	// ----------------------------------------------------------
	typedef struct packed {
		logic signed [ELEM_W-1:0] re;
		logic signed [ELEM_W-1:0] im;
	} complex_t;

	// word 0 of the input SRAM
	typedef struct packed {
		logic [CNT_W-1:0] q;
		logic [CNT_W-1:0] m;
	} header_t;

	// ----------------------------------------------------------
	// block to block requests
	// ----------------------------------------------------------
	typedef struct packed {
		logic                  valid;
		logic                  first;       // clears the accumulator
		logic                  last;        // element complete
		logic                  from_input;  // gate 0 reads the input SRAM
		logic                  final_gate;  // result goes to the output SRAM
		logic [BUF_ADDR_W-1:0] row;
		logic                  wr_bank;
	} mac_cmd_t;

	typedef struct packed {
		logic                  en;
		logic                  bank;
		logic [BUF_ADDR_W-1:0] row;
		complex_t              data;
	} buf_wr_t;

	typedef struct packed {
		logic                  bank;
		logic [BUF_ADDR_W-1:0] row;
	} buf_rd_t;

	typedef struct packed {
		logic                    en;
		logic [STATE_ADDR_W-1:0] addr;
		complex_t                data;
	} out_wr_t;

	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		LOAD,
		RUN,
		DRAIN,
		DONE
	} seq_state_e;

endpackage

`default_nettype wire

// File: rtl/qsim_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_sequencer (
	input  wire                                clk,
	input  wire                                reset_n,
	input  wire                                dut_valid,
	output logic                               dut_ready,
	output logic [qsim_pkg::STATE_ADDR_W-1:0]  in_rd_addr,
	input  wire qsim_pkg::complex_t            in_rd_data,
	output logic [qsim_pkg::GATE_ADDR_W-1:0]   gate_rd_addr,
	output qsim_pkg::buf_rd_t                  buf_rd,
	output qsim_pkg::mac_cmd_t                 mac_cmd
);
	import qsim_pkg::*;

	seq_state_e            state;
	header_t               hdr;
	logic [BUF_ADDR_W-1:0] last_idx;   // 2^q - 1
	logic [CNT_W-1:0]      last_gate;  // m - 1
	logic [CNT_W-1:0]      gate_cnt;
	logic [BUF_ADDR_W-1:0] row_cnt;
	logic [BUF_ADDR_W-1:0] col_cnt;
	logic [BUF_ADDR_W-1:0] drain_cnt;
	logic                  final_pass;  // drain in progress belongs to the last gate
	logic                  row_end;
	logic                  gate_end;
	mac_cmd_t              cmd_next;

	assign hdr       = header_t'(in_rd_data);
	assign dut_ready = (state == IDLE);
	assign row_end   = (col_cnt == last_idx);
	assign gate_end  = row_end && (row_cnt == last_idx);

	// column walks the buffer rows, gate g reads the bank gate g-1 wrote
	assign buf_rd = '{bank: ~gate_cnt[0], row: col_cnt};

	// ----------------------------------------------------------
	// term descriptor for the MAC
	// ----------------------------------------------------------
	always_comb begin
		cmd_next = '0;
		if (state == RUN) begin
			cmd_next.valid      = 1'b1;
			cmd_next.first      = (col_cnt == '0);
			cmd_next.last       = row_end;
			cmd_next.from_input = (gate_cnt == '0);
			cmd_next.final_gate = (gate_cnt == last_gate);
			cmd_next.row        = row_cnt;
			cmd_next.wr_bank    = gate_cnt[0];
		end
	end

	// one cycle behind the addresses, lines up with the read data
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mac_cmd <= '0;
		end else begin
			mac_cmd <= cmd_next;
		end
	end

	// ----------------------------------------------------------
	// control FSM and counters
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state        <= IDLE;
			in_rd_addr   <= '0;
			gate_rd_addr <= '0;
			last_idx     <= '0;
			last_gate    <= '0;
			gate_cnt     <= '0;
			row_cnt      <= '0;
			col_cnt      <= '0;
			drain_cnt    <= '0;
			final_pass   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (dut_valid) begin
						in_rd_addr <= '0;  // header word
						state      <= HEADER;
					end
				end

				HEADER: begin
					state <= LOAD;  // header read in flight
				end

				LOAD: begin
					last_idx     <= BUF_ADDR_W'((1 << hdr.q) - 1);
					last_gate    <= hdr.m - 1'b1;
					gate_cnt     <= '0;
					row_cnt      <= '0;
					col_cnt      <= '0;
					in_rd_addr   <= STATE_ADDR_W'(1);  // first vector element
					gate_rd_addr <= '0;
					final_pass   <= 1'b0;
					state        <= RUN;
				end

				RUN: begin
					// gates sit back to back, row-major
					gate_rd_addr <= gate_rd_addr + 1'b1;
					if (!row_end) begin
						col_cnt    <= col_cnt + 1'b1;
						in_rd_addr <= in_rd_addr + 1'b1;
					end else begin
						col_cnt    <= '0;
						in_rd_addr <= STATE_ADDR_W'(1);  // rewind for the next row
						if (!gate_end) begin
							row_cnt <= row_cnt + 1'b1;
						end else begin
							row_cnt    <= '0;
							gate_cnt   <= gate_cnt + 1'b1;
							final_pass <= (gate_cnt == last_gate);
							drain_cnt  <= '0;
							state      <= DRAIN;
						end
					end
				end

				// let the last rows land before the next gate reads them
				DRAIN: begin
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == BUF_ADDR_W'(MAC_DEPTH - 1)) begin
						state <= final_pass ? DONE : RUN;
					end
				end

				DONE: begin
					state <= IDLE;  // last output write done by now
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/qsim_top.sv
`timescale 1ns/1ps
`default_nettype none

module qsim_top (
	// ----------------------------------------------------------
	// clock, reset, control
	input  wire                                clk,
	input  wire                                reset_n,
	input  wire                                dut_valid,
	output logic                               dut_ready,

	// ----------------------------------------------------------
	// input state SRAM, read only
	output logic [qsim_pkg::STATE_ADDR_W-1:0]  in_rd_addr,
	input  wire qsim_pkg::complex_t            in_rd_data,

	// ----------------------------------------------------------
	// gate SRAM, read only
	output logic [qsim_pkg::GATE_ADDR_W-1:0]   gate_rd_addr,
	input  wire qsim_pkg::complex_t            gate_rd_data,

	// ----------------------------------------------------------
	// output state SRAM, write only
	output qsim_pkg::out_wr_t                  out_wr
);
	import qsim_pkg::*;

	buf_rd_t  buf_rd;       // sequencer -> buffer
	complex_t buf_rd_data;  // buffer -> MAC
	buf_wr_t  buf_wr;       // MAC -> buffer
	mac_cmd_t mac_cmd;      // sequencer -> MAC

	// producer
	qsim_sequencer u_seq (
		.clk          (clk),
		.reset_n      (reset_n),
		.dut_valid    (dut_valid),
		.dut_ready    (dut_ready),
		.in_rd_addr   (in_rd_addr),
		.in_rd_data   (in_rd_data),
		.gate_rd_addr (gate_rd_addr),
		.buf_rd       (buf_rd),
		.mac_cmd      (mac_cmd)
	);

	// intermediate vectors between gates
	state_buffer u_buf (
		.clk         (clk),
		.buf_wr      (buf_wr),
		.buf_rd      (buf_rd),
		.buf_rd_data (buf_rd_data)
	);

	// consumer
	complex_mac u_mac (
		.clk       (clk),
		.reset_n   (reset_n),
		.mac_cmd   (mac_cmd),
		.gate_data (gate_rd_data),
		.in_data   (in_rd_data),
		.buf_data  (buf_rd_data),
		.buf_wr    (buf_wr),
		.out_wr    (out_wr)
	);

endmodule

`default_nettype wire

// File: rtl/state_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module state_buffer (
	input  wire                     clk,
	input  wire qsim_pkg::buf_wr_t  buf_wr,
	input  wire qsim_pkg::buf_rd_t  buf_rd,
	output qsim_pkg::complex_t      buf_rd_data
);
	import qsim_pkg::*;

	// ----------------------------------------------------------
	// ping-pong storage
	// ----------------------------------------------------------
	// one bank takes the rows of the gate in progress while the
	// other still holds the vector the gate is consuming
	complex_t bank0 [MAX_STATES];
	complex_t bank1 [MAX_STATES];

	always_ff @(posedge clk) begin
		if (buf_wr.en && !buf_wr.bank) begin
			bank0[buf_wr.row] <= buf_wr.data;
		end
		if (buf_wr.en && buf_wr.bank) begin
			bank1[buf_wr.row] <= buf_wr.data;
		end
	end

	// registered read, data follows the request by one cycle
	always_ff @(posedge clk) begin
		if (buf_rd.bank) begin
			buf_rd_data <= bank1[buf_rd.row];
		end else begin
			buf_rd_data <= bank0[buf_rd.row];
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator from src.f, run, and look for the pass line in the output
verilator --binary --top-module tb_qsim -f src.f -o tb_qsim \
	&& ./obj_dir/tb_qsim | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
	&& echo "run_sim: ok" \
	|| { echo "run_sim: failed"; exit 1; }

// File: sim/tb_qsim.sv
`timescale 1ns/1ps
`default_nettype none

module tb_qsim;
	import qsim_pkg::*;

	logic                    clk;
	logic                    reset_n;
	logic                    dut_valid;
	logic                    dut_ready;
	logic                    mem_clear;
	logic [STATE_ADDR_W-1:0] in_rd_addr;
	complex_t                in_rd_data;
	logic [GATE_ADDR_W-1:0]  gate_rd_addr;
	complex_t                gate_rd_data;
	out_wr_t                 out_wr;
	complex_t                expect_vec [MAX_STATES];  // reference vector, gate by gate
	int                      errors;
	int                      checks;
	int                      budget;

	qsim_top u_dut (.*);
	ext_sram_model u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// watchdog sized from the runs below, twice over
	initial begin
		budget = run_cycles(1, 1) + run_cycles(2, 1) + run_cycles(3, 3)
			+ run_cycles(2, 2) + run_cycles(4, 2) + run_cycles(1, 1);
		#(budget * 2 * 8);
		$display("timeout: DUT still busy after %0d cycles", budget * 2);
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic int run_cycles(input int q, input int m);
		return m * ((1 << (2 * q)) + 40);
	endfunction

	function automatic complex_t rand_elem();
		complex_t c;
		c.re = ELEM_W'(int'($urandom % 16385) - 8192);  // -0.5 .. +0.5
		c.im = ELEM_W'(int'($urandom % 16385) - 8192);
		return c;
	endfunction

	task automatic check_elem(input string name, input int idx, input complex_t exp,
		input complex_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s elem %0d: expected (%0d, %0d) actual (%0d, %0d)",
				name, idx, exp.re, exp.im, act.re, act.im);
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %0b actual %0b", name, exp, act);
		end
	endtask

	task automatic load_header(input int q, input int m);
		header_t h;
		h.q = CNT_W'(q);
		h.m = CNT_W'(m);
		u_mem.in_mem[0] = complex_t'(h);
	endtask

	task automatic load_random(input int q, input int m);
		load_header(q, m);
		for (int i = 1; i <= (1 << q); i++) begin
			u_mem.in_mem[i] = rand_elem();
		end
		for (int a = 0; a < (m << (2 * q)); a++) begin
			u_mem.gate_mem[a] = rand_elem();
		end
	endtask

	// exact products, row sums, >>> FRAC_BITS, keep the low 16 bits
	task automatic compute_expected(input int q, input int m);
		int       n;
		longint   acc_re;
		longint   acc_im;
		complex_t g;
		complex_t s;
		complex_t nxt [MAX_STATES];
		n = 1 << q;
		for (int i = 0; i < n; i++) begin
			expect_vec[i] = u_mem.in_mem[i + 1];
		end
		for (int k = 0; k < m; k++) begin
			for (int r = 0; r < n; r++) begin
				acc_re = 0;
				acc_im = 0;
				for (int c = 0; c < n; c++) begin
					g = u_mem.gate_mem[(k * n + r) * n + c];  // row-major, gates back to back
					s = expect_vec[c];
					acc_re += longint'(g.re) * longint'(s.re)
						- longint'(g.im) * longint'(s.im);
					acc_im += longint'(g.re) * longint'(s.im)
						+ longint'(g.im) * longint'(s.re);
				end
				nxt[r].re = ELEM_W'(acc_re >>> FRAC_BITS);
				nxt[r].im = ELEM_W'(acc_im >>> FRAC_BITS);
			end
			expect_vec = nxt;  // feeds the next gate
		end
	endtask

	// start a run, wait for dut_ready, compare the output SRAM
	task automatic run_and_check(input string name, input int q, input int m,
		input bit poke);
		compute_expected(q, m);
		dut_valid = 1'b1;
		mem_clear = 1'b1;  // fresh write map
		@(posedge clk);
		#1;
		dut_valid = 1'b0;
		mem_clear = 1'b0;
		check_ready(name, 1'b0, dut_ready);
		// optional dut_valid pulses while busy
		do begin
			@(posedge clk);
			#1;
			dut_valid = poke && !dut_valid && !dut_ready;
		end while (!dut_ready);
		for (int i = 0; i < (1 << q); i++) begin
			check_elem(name, i, expect_vec[i], u_mem.out_mem[i]);
		end
		check_ready(name, 1'b1, u_mem.out_mask == 32'((1 << (1 << q)) - 1));
		@(posedge clk);
		#1;
		check_ready(name, 1'b1, dut_ready);  // no stray restart
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic reset_idle_test();
		repeat (4) begin
			@(posedge clk);
			#1;
			check_ready("reset_idle", 1'b1, dut_ready);
			check_ready("reset_idle", 1'b0, out_wr.en);
		end
	endtask

	task automatic identity_test();
		load_random(1, 1);
		// 1.0 on the diagonal
		for (int a = 0; a < 4; a++) begin
			u_mem.gate_mem[a] = '{re: (a == 0 || a == 3) ? 16'sd16384 : 16'sd0, im: 16'sd0};
		end
		run_and_check("identity_q1m1", 1, 1, 1'b0);
		for (int i = 0; i < 2; i++) begin
			check_elem("identity_vs_input", i, u_mem.in_mem[i + 1], u_mem.out_mem[i]);
		end
	endtask

	task automatic random_test(input string name, input int q, input int m);
		load_random(q, m);
		run_and_check(name, q, m, 1'b0);
	endtask

	// imaginary gate first, real part then comes only from -bd
	task automatic sign_test();
		load_header(2, 2);
		for (int i = 0; i < 4; i++) begin
			u_mem.in_mem[i + 1] = '{re: ELEM_W'(-3000 * i - 1234), im: ELEM_W'(2500 * i - 5001)};
		end
		for (int a = 0; a < 16; a++) begin
			u_mem.gate_mem[a]      = '{re: 16'sd0, im: ELEM_W'(523 * a - 4333)};
			u_mem.gate_mem[a + 16] = '{re: ELEM_W'(-397 * a + 2999), im: 16'sd0};
		end
		run_and_check("neg_frac_q2m2", 2, 2, 1'b0);
	endtask

	task automatic back_to_back_test();
		load_random(4, 2);
		run_and_check("b2b_q4m2", 4, 2, 1'b1);
		load_random(1, 1);
		run_and_check("b2b_q1m1", 1, 1, 1'b0);  // write map limits it to 0..1
	endtask

	initial begin
		void'($urandom(89));
		errors    = 0;
		checks    = 0;
		reset_n   = 1'b0;
		dut_valid = 1'b0;
		mem_clear = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset_n = 1'b1;
		reset_idle_test();
		identity_test();
		random_test("rand_q2m1", 2, 1);
		random_test("chain_q3m3", 3, 3);
		sign_test();
		back_to_back_test();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tb_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module ext_sram_model (
	input  wire                               clk,
	input  wire                               mem_clear,
	input  wire [qsim_pkg::STATE_ADDR_W-1:0]  in_rd_addr,
	output qsim_pkg::complex_t                in_rd_data,
	input  wire [qsim_pkg::GATE_ADDR_W-1:0]   gate_rd_addr,
	output qsim_pkg::complex_t                gate_rd_data,
	input  wire qsim_pkg::out_wr_t            out_wr
);
	import qsim_pkg::*;

	complex_t                        in_mem   [1 << STATE_ADDR_W];  // word 0 holds the header
	complex_t                        gate_mem [1 << GATE_ADDR_W];
	complex_t                        out_mem  [1 << STATE_ADDR_W];
	logic [(1 << STATE_ADDR_W)-1:0]  out_mask;  // addresses written since the last clear

	// both ROMs answer one edge after the address
	always @(posedge clk) begin
		in_rd_data   <= in_mem[in_rd_addr];
		gate_rd_data <= gate_mem[gate_rd_addr];
	end

	always @(posedge clk) begin
		if (mem_clear) begin
			out_mask <= '0;
		end else if (out_wr.en) begin
			out_mem[out_wr.addr]  <= out_wr.data;
			out_mask[out_wr.addr] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src.f
rtl/qsim_pkg.sv
rtl/qsim_sequencer.sv
rtl/state_buffer.sv
rtl/complex_mac.sv
rtl/qsim_top.sv
sim/tb_sram_model.sv
sim/tb_qsim.sv
